/* csr_access_ctrl.sv */
// Decodes one CSR request and applies the access rules.
// Read data and the illegal flag are combinational in the request cycle.
// Register blocks must return zero read data when they do not hit.
`timescale 1ns/10ps
`default_nettype none

module csr_access_ctrl (
  input  logic               csr_access_i,
  input  logic               instr_new_id_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  csr_pkg::xlen_t     csr_wdata_i,
  input  csr_pkg::priv_lvl_e priv_lvl_i,
  input  logic               mach_hit_i,
  input  logic               cnt_hit_i,
  input  csr_pkg::xlen_t     mach_rdata_i,
  input  csr_pkg::xlen_t     cnt_rdata_i,
  output csr_pkg::xlen_t     csr_rdata_o,
  output csr_pkg::xlen_t     csr_wdata_o,
  output logic               csr_we_o,
  output logic               illegal_csr_insn_o
);

  import csr_pkg::*;

  logic misa_sel;
  logic illegal_addr;
  logic illegal_priv;
  logic illegal_write;
  logic wreq;

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  assign misa_sel = (csr_addr_i == CSR_MISA);  // constant, lives here

  // at most one source is nonzero
  assign csr_rdata_o = mach_rdata_i | cnt_rdata_i | (misa_sel ? MISA_VALUE : '0);

  ////////////////////////////////////////////////////////////
  // access rules
  ////////////////////////////////////////////////////////////

  assign wreq = (csr_op_i != CSR_OP_READ);

  assign illegal_addr  = ~(mach_hit_i | cnt_hit_i | misa_sel);
  assign illegal_priv  = (csr_addr_i[9:8] > priv_lvl_i);  // min level in bits 9:8
  assign illegal_write = (&csr_addr_i[11:10]) & wreq;     // read-only space

  assign illegal_csr_insn_o = csr_access_i & (illegal_addr | illegal_priv | illegal_write);

  // set and clear work on the current value
  always_comb begin
    case (csr_op_i)
      CSR_OP_WRITE: csr_wdata_o = csr_wdata_i;
      CSR_OP_SET:   csr_wdata_o = csr_rdata_o | csr_wdata_i;
      CSR_OP_CLEAR: csr_wdata_o = csr_rdata_o & ~csr_wdata_i;
      default:      csr_wdata_o = csr_wdata_i;  // read
    endcase
  end

  // one strobe per new instruction in ID
  assign csr_we_o = csr_access_i & instr_new_id_i & wreq & ~illegal_csr_insn_o;

endmodule

`default_nettype wire

/* csr_machine_regs.sv */
// Machine trap registers, privilege level and interrupt pending logic.
// Trap entry and MRET override a CSR write to the same register.
// mtvec is always vectored with a 256-byte aligned base.
`timescale 1ns/10ps
`default_nettype none

module csr_machine_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                csr_we_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::xlen_t      csr_wdata_i,
  input  logic                irq_software_i,
  input  logic                irq_timer_i,
  input  logic                irq_external_i,
  input  csr_pkg::fast_irq_t  irq_fast_i,
  input  logic                csr_save_cause_i,
  input  logic                csr_save_if_i,
  input  logic                csr_save_id_i,
  input  logic                csr_restore_mret_i,
  input  csr_pkg::xlen_t      pc_if_i,
  input  csr_pkg::xlen_t      pc_id_i,
  input  csr_pkg::xlen_t      csr_mtval_i,
  input  csr_pkg::cause_t     csr_mcause_i,
  output logic                hit_o,
  output csr_pkg::xlen_t      rdata_o,
  output csr_pkg::priv_lvl_e  priv_lvl_o,
  output csr_pkg::xlen_t      csr_mtvec_o,
  output csr_pkg::xlen_t      csr_mepc_o,
  output logic                csr_mstatus_mie_o,
  output logic                csr_mstatus_tw_o,
  output logic                irq_pending_o
);

  import csr_pkg::*;

  // writable bits of mie and mip
  localparam xlen_t MieMask = (32'h1 << MSIX_BIT)
                            | (32'h1 << MTIX_BIT)
                            | (32'h1 << MEIX_BIT)
                            | (32'h7fff << MFIX_LO);

  priv_lvl_e priv_lvl_q;
  logic      mstatus_mie_q;
  logic      mstatus_mpie_q;
  priv_lvl_e mstatus_mpp_q;
  logic      mstatus_mprv_q;
  logic      mstatus_tw_q;
  xlen_t     mie_q;
  xlen_t     mscratch_q;
  xlen_t     mepc_q;
  cause_t    mcause_q;
  xlen_t     mtval_q;
  xlen_t     mtvec_q;
  xlen_t     irq_lines;
  xlen_t     mip;
  xlen_t     exception_pc;
  priv_lvl_e mpp_wr;

  ////////////////////////////////////////////////////////////
  // interrupts
  ////////////////////////////////////////////////////////////

  always_comb begin
    irq_lines                   = '0;
    irq_lines[MSIX_BIT]         = irq_software_i;
    irq_lines[MTIX_BIT]         = irq_timer_i;
    irq_lines[MEIX_BIT]         = irq_external_i;
    irq_lines[MFIX_LO +: 15]    = irq_fast_i;
  end

  assign mip           = irq_lines & mie_q;  // mie_q only holds legal bits
  assign irq_pending_o = |mip;

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        rdata_o[MSTATUS_MIE_BIT]       = mstatus_mie_q;
        rdata_o[MSTATUS_MPIE_BIT]      = mstatus_mpie_q;
        rdata_o[MSTATUS_MPP_LO +: 2]   = mstatus_mpp_q;
        rdata_o[MSTATUS_MPRV_BIT]      = mstatus_mprv_q;
        rdata_o[MSTATUS_TW_BIT]        = mstatus_tw_q;
      end
      CSR_MIE:      rdata_o = mie_q;
      CSR_MTVEC:    rdata_o = mtvec_q;
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MCAUSE:   rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MTVAL:    rdata_o = mtval_q;
      CSR_MIP:      rdata_o = mip;  // writes ignored
      default:      hit_o   = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  // reserved mpp encodings fall back to machine
  assign mpp_wr = (csr_wdata_i[MSTATUS_MPP_LO +: 2] == PRIV_LVL_U) ? PRIV_LVL_U : PRIV_LVL_M;

  // id pc wins if the core ever flags both
  assign exception_pc = (csr_save_if_i && !csr_save_id_i) ? pc_if_i : pc_id_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_lvl_q     <= PRIV_LVL_M;
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b1;
      mstatus_mpp_q  <= PRIV_LVL_U;
      mstatus_mprv_q <= 1'b0;
      mstatus_tw_q   <= 1'b0;
      mie_q          <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mtvec_q        <= MTVEC_RESET;
    end else begin
      if (csr_we_i) begin
        case (csr_addr_i)
          CSR_MSTATUS: begin
            mstatus_mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
            mstatus_mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
            mstatus_mpp_q  <= mpp_wr;
            mstatus_mprv_q <= csr_wdata_i[MSTATUS_MPRV_BIT];
            mstatus_tw_q   <= csr_wdata_i[MSTATUS_TW_BIT];
          end
          CSR_MIE:      mie_q      <= csr_wdata_i & MieMask;
          CSR_MTVEC:    mtvec_q    <= {csr_wdata_i[31:8], 6'b0, 2'b01};
          CSR_MSCRATCH: mscratch_q <= csr_wdata_i;
          CSR_MEPC:     mepc_q     <= {csr_wdata_i[31:1], 1'b0};
          CSR_MCAUSE:   mcause_q   <= {csr_wdata_i[31], csr_wdata_i[4:0]};
          CSR_MTVAL:    mtval_q    <= csr_wdata_i;
          default: ;
        endcase
      end

      // later assignments win over the csr write above
      if (csr_save_cause_i) begin
        priv_lvl_q     <= PRIV_LVL_M;
        mstatus_mie_q  <= 1'b0;           // mask interrupts
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mpp_q  <= priv_lvl_q;
        mepc_q         <= exception_pc;
        mcause_q       <= csr_mcause_i;
        mtval_q        <= csr_mtval_i;
      end else if (csr_restore_mret_i) begin
        priv_lvl_q     <= mstatus_mpp_q;
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
        mstatus_mpp_q  <= PRIV_LVL_U;
      end
    end
  end

  assign priv_lvl_o        = priv_lvl_q;
  assign csr_mtvec_o       = mtvec_q;
  assign csr_mepc_o        = mepc_q;
  assign csr_mstatus_mie_o = mstatus_mie_q;
  assign csr_mstatus_tw_o  = mstatus_tw_q;

endmodule

`default_nettype wire

/* csr_perf_counters.sv */
// mcycle, minstret, hardwired event counters and mcountinhibit.
// Event counters 3..6 count loads, stores, branches and taken branches.
// Unimplemented counters read zero and mcountinhibit bits above them read one.
`timescale 1ns/10ps
`default_nettype none

module csr_perf_counters #(
  parameter int NumEventCounters  = 4,   // 0 to 4
  parameter int EventCounterWidth = 40   // 33 to 64
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               csr_we_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::xlen_t     csr_wdata_i,
  input  logic               instr_ret_i,
  input  logic               mem_load_i,
  input  logic               mem_store_i,
  input  logic               branch_i,
  input  logic               branch_taken_i,
  output logic               hit_o,
  output csr_pkg::xlen_t     rdata_o
);

  import csr_pkg::*;

  localparam int NumCnt = 3 + NumEventCounters;  // index 1 is reserved

  logic [4:0]        cnt_idx;
  logic              lo_sel;
  logic              hi_sel;
  logic              inh_sel;
  logic              inh_we;
  logic [6:0]        incr_all;
  logic [NumCnt-1:0] incr;
  logic [NumCnt-1:0] inhibit_q;
  logic [NumCnt-1:0] inhibit_wdata;
  logic [NumCnt-1:0] inhibit_eff;
  logic [63:0]       cnt_rd [NumCnt];
  logic [63:0]       cnt_sel;

  assign cnt_idx = csr_addr_i[4:0];
  assign lo_sel  = (csr_addr_i[11:5] == CSR_MCYCLE[11:5]);
  assign hi_sel  = (csr_addr_i[11:5] == CSR_MCYCLEH[11:5]);
  assign inh_sel = (csr_addr_i == CSR_MCOUNTINHIBIT);
  assign hit_o   = inh_sel | ((lo_sel | hi_sel) & (cnt_idx != 5'd1));

  // events by counter index
  assign incr_all = {branch_taken_i, branch_i, mem_store_i, mem_load_i,
                     instr_ret_i, 1'b0, 1'b1};
  assign incr     = incr_all[NumCnt-1:0];

  ////////////////////////////////////////////////////////////
  // mcountinhibit
  ////////////////////////////////////////////////////////////

  assign inh_we        = csr_we_i & inh_sel;
  assign inhibit_wdata = {csr_wdata_i[NumCnt-1:2], 1'b0, csr_wdata_i[0]};

  // new value already gates the edge it is written at
  assign inhibit_eff = inh_we ? inhibit_wdata : inhibit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (inh_we) begin
      inhibit_q <= inhibit_wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumCnt; i++) begin : g_cnt
    if (i == 1) begin : g_reserved
      assign cnt_rd[i] = '0;
    end else begin : g_flops
      localparam int CntWidth = (i < 3) ? 64 : EventCounterWidth;

      logic [CntWidth-1:0] cnt_q;
      logic                wr_lo;
      logic                wr_hi;

      assign wr_lo = csr_we_i & lo_sel & (cnt_idx == 5'(i));
      assign wr_hi = csr_we_i & hi_sel & (cnt_idx == 5'(i));

      // a write to either half beats the increment
      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          cnt_q <= '0;
        end else if (wr_lo) begin
          cnt_q[31:0] <= csr_wdata_i;
        end else if (wr_hi) begin
          cnt_q[CntWidth-1:32] <= csr_wdata_i[CntWidth-33:0];
        end else if (incr[i] && !inhibit_eff[i]) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end

      assign cnt_rd[i] = 64'(cnt_q);  // zero-extended
    end
  end

  always_comb begin
    cnt_sel = '0;
    for (int i = 0; i < NumCnt; i++) begin
      if (cnt_idx == 5'(i)) cnt_sel = cnt_rd[i];
    end
  end

  always_comb begin
    rdata_o = '0;
    if (inh_sel) begin
      rdata_o = {{(32-NumCnt){1'b1}}, inhibit_q};
    end else if (lo_sel) begin
      rdata_o = cnt_sel[31:0];
    end else if (hi_sel) begin
      rdata_o = cnt_sel[63:32];
    end
  end

endmodule

`default_nettype wire

/* csr_pkg.sv */
// Shared widths, CSR numbers and field positions for the CSR unit.
// Only user and machine privilege levels exist.
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] xlen_t;      // csr data and pcs
  typedef logic [11:0] csr_addr_t;
  typedef logic [5:0]  cause_t;     // irq flag on top of 5-bit code
  typedef logic [14:0] fast_irq_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////
  // csr numbers
  ////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MISA     = 12'h301;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MIP      = 12'h344;

  // event counters 4..6 follow on consecutively
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
  localparam csr_addr_t CSR_MHPMCOUNTER3  = 12'hB03;
  localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;
  localparam csr_addr_t CSR_MHPMCOUNTER3H = 12'hB83;

  ////////////////////////////////////////////////////////////
  // field positions
  ////////////////////////////////////////////////////////////

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;  // two bits wide
  localparam int MSTATUS_MPRV_BIT = 17;
  localparam int MSTATUS_TW_BIT   = 21;

  localparam int MSIX_BIT = 3;
  localparam int MTIX_BIT = 7;
  localparam int MEIX_BIT = 11;
  localparam int MFIX_LO  = 16;  // 15 fast lines from here up

  // RV32 with C, I and U only
  localparam xlen_t MISA_VALUE = (32'd1 << 2)    // C
                               | (32'd1 << 8)    // I
                               | (32'd1 << 20)   // U
                               | (32'd1 << 30);  // mxl = 1

  localparam xlen_t MTVEC_RESET = 32'h0000_0001;  // base 0 in vectored mode

endpackage

`default_nettype wire

/* csr_unit.f */
csr_pkg.sv
csr_access_ctrl.sv
csr_machine_regs.sv
csr_perf_counters.sv
csr_unit.sv
csr_unit_props.sv
tb_csr_unit.sv

/* csr_unit.sv */
// Machine-mode CSR unit for a small RV32 core.
// Request inputs must be held stable through the cycle.
// There is no back-pressure anywhere.
`timescale 1ns/10ps
`default_nettype none

module csr_unit #(
  parameter int NumEventCounters  = 4,
  parameter int EventCounterWidth = 40
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // csr access
  input  logic               csr_access_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  csr_pkg::xlen_t     csr_wdata_i,
  input  logic               instr_new_id_i,
  output csr_pkg::xlen_t     csr_rdata_o,
  output logic               illegal_csr_insn_o,
  // interrupts
  input  logic               irq_software_i,
  input  logic               irq_timer_i,
  input  logic               irq_external_i,
  input  csr_pkg::fast_irq_t irq_fast_i,
  output logic               irq_pending_o,
  // trap entry and return
  input  logic               csr_save_cause_i,
  input  logic               csr_save_if_i,
  input  logic               csr_save_id_i,
  input  logic               csr_restore_mret_i,
  input  csr_pkg::xlen_t     pc_if_i,
  input  csr_pkg::xlen_t     pc_id_i,
  input  csr_pkg::xlen_t     csr_mtval_i,
  input  csr_pkg::cause_t    csr_mcause_i,
  output csr_pkg::priv_lvl_e priv_mode_o,
  output csr_pkg::xlen_t     csr_mtvec_o,
  output csr_pkg::xlen_t     csr_mepc_o,
  output logic               csr_mstatus_mie_o,
  output logic               csr_mstatus_tw_o,
  // counter events
  input  logic               instr_ret_i,
  input  logic               mem_load_i,
  input  logic               mem_store_i,
  input  logic               branch_i,
  input  logic               branch_taken_i
);

  import csr_pkg::*;

  logic      csr_we;
  xlen_t     csr_wdata_int;
  priv_lvl_e priv_lvl;
  logic      mach_hit;
  logic      cnt_hit;
  xlen_t     mach_rdata;
  xlen_t     cnt_rdata;

  assign priv_mode_o = priv_lvl;

  csr_access_ctrl u_access_ctrl (
    .csr_access_i       (csr_access_i),
    .instr_new_id_i     (instr_new_id_i),
    .csr_addr_i         (csr_addr_i),
    .csr_op_i           (csr_op_i),
    .csr_wdata_i        (csr_wdata_i),
    .priv_lvl_i         (priv_lvl),
    .mach_hit_i         (mach_hit),
    .cnt_hit_i          (cnt_hit),
    .mach_rdata_i       (mach_rdata),
    .cnt_rdata_i        (cnt_rdata),
    .csr_rdata_o        (csr_rdata_o),
    .csr_wdata_o        (csr_wdata_int),
    .csr_we_o           (csr_we),
    .illegal_csr_insn_o (illegal_csr_insn_o)
  );

  csr_machine_regs u_machine_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_we_i           (csr_we),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata_int),
    .irq_software_i     (irq_software_i),
    .irq_timer_i        (irq_timer_i),
    .irq_external_i     (irq_external_i),
    .irq_fast_i         (irq_fast_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_mtval_i        (csr_mtval_i),
    .csr_mcause_i       (csr_mcause_i),
    .hit_o              (mach_hit),
    .rdata_o            (mach_rdata),
    .priv_lvl_o         (priv_lvl),
    .csr_mtvec_o        (csr_mtvec_o),
    .csr_mepc_o         (csr_mepc_o),
    .csr_mstatus_mie_o  (csr_mstatus_mie_o),
    .csr_mstatus_tw_o   (csr_mstatus_tw_o),
    .irq_pending_o      (irq_pending_o)
  );

  csr_perf_counters #(
    .NumEventCounters  (NumEventCounters),
    .EventCounterWidth (EventCounterWidth)
  ) u_perf_counters (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .csr_we_i       (csr_we),
    .csr_addr_i     (csr_addr_i),
    .csr_wdata_i    (csr_wdata_int),
    .instr_ret_i    (instr_ret_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .branch_i       (branch_i),
    .branch_taken_i (branch_taken_i),
    .hit_o          (cnt_hit),
    .rdata_o        (cnt_rdata)
  );

endmodule

`default_nettype wire

/* csr_unit_props.sv */
// Interface properties for csr_unit, bound into every csr_unit instance.
// Checks are disabled while rst_ni is low.
`timescale 1ns/10ps
`default_nettype none

module csr_unit_props (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               csr_access_i,
  input csr_pkg::csr_op_e   csr_op_i,
  input csr_pkg::xlen_t     csr_wdata_i,
  input logic               illegal_csr_insn_o,
  input logic               csr_save_cause_i,
  input csr_pkg::priv_lvl_e priv_mode_o
);

  import csr_pkg::*;

  int fail_count = 0;  // summed up by the testbench

  op_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_access_i |-> !$isunknown(csr_op_i))
    else begin
      fail_count++;
      $error("csr_op_i is unknown during an access");
    end

  illegal_needs_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
      illegal_csr_insn_o |-> csr_access_i)
    else begin
      fail_count++;
      $error("illegal_csr_insn_o high without csr_access_i");
    end

  wdata_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_access_i |-> !$isunknown(csr_wdata_i))
    else begin
      fail_count++;
      $error("csr_wdata_i is unknown during an access");
    end

  // trap always lands in machine mode
  trap_to_machine: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_save_cause_i |=> (priv_mode_o == PRIV_LVL_M))
    else begin
      fail_count++;
      $error("priv_mode_o not machine after a trap");
    end

endmodule

bind csr_unit csr_unit_props u_props (
  .clk_i              (clk_i),
  .rst_ni             (rst_ni),
  .csr_access_i       (csr_access_i),
  .csr_op_i           (csr_op_i),
  .csr_wdata_i        (csr_wdata_i),
  .illegal_csr_insn_o (illegal_csr_insn_o),
  .csr_save_cause_i   (csr_save_cause_i),
  .priv_mode_o        (priv_mode_o)
);

`default_nettype wire

/* tb_csr_unit.sv */
// Table-driven testbench for csr_unit.
// Every row starts 2 ns after a rising edge and leaves the request inputs idle.
// Needs a simulator with bind support for the property checks.
`timescale 1ns/10ps
`default_nettype none

module tb_csr_unit;

  import csr_pkg::*;

  localparam int KOp   = 0;  // one csr access
  localparam int KTrap = 1;
  localparam int KMret = 2;
  localparam int KIdle = 3;  // idle cycles, irq lines and load pulses from wdata

  logic      clk_i;
  logic      rst_ni;
  logic      csr_access_i;
  csr_addr_t csr_addr_i;
  csr_op_e   csr_op_i;
  xlen_t     csr_wdata_i;
  logic      instr_new_id_i;
  xlen_t     csr_rdata_o;
  logic      illegal_csr_insn_o;
  logic      irq_software_i;
  logic      irq_timer_i;
  logic      irq_external_i;
  fast_irq_t irq_fast_i;
  logic      irq_pending_o;
  logic      csr_save_cause_i;
  logic      csr_save_if_i;
  logic      csr_save_id_i;
  logic      csr_restore_mret_i;
  xlen_t     pc_if_i;
  xlen_t     pc_id_i;
  xlen_t     csr_mtval_i;
  cause_t    csr_mcause_i;
  priv_lvl_e priv_mode_o;
  xlen_t     csr_mtvec_o;
  xlen_t     csr_mepc_o;
  logic      csr_mstatus_mie_o;
  logic      csr_mstatus_tw_o;
  logic      instr_ret_i;
  logic      mem_load_i;
  logic      mem_store_i;
  logic      branch_i;
  logic      branch_taken_i;

  ////////////////////////////////////////////////////////////
  // test table
  ////////////////////////////////////////////////////////////

  string     t_name[$];
  int        t_kind[$];
  csr_addr_t t_addr[$];
  csr_op_e   t_op[$];
  xlen_t     t_wdata[$];
  int        t_count[$];
  xlen_t     t_exp[$];
  xlen_t     t_mask[$];   // zero means no value check
  logic      t_illegal[$];

  logic [31:0] seed;
  bit          table_done;
  int          errors;
  int          passed;
  int          prop_fails;

  csr_unit #(
    .NumEventCounters  (4),
    .EventCounterWidth (40)
  ) csr_unit_inst (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_row(input string name, input int kind, input csr_addr_t addr,
                         input csr_op_e op, input xlen_t wdata, input int count,
                         input xlen_t exp, input xlen_t mask, input logic illegal);
    t_name.push_back(name);
    t_kind.push_back(kind);
    t_addr.push_back(addr);
    t_op.push_back(op);
    t_wdata.push_back(wdata);
    t_count.push_back(count);
    t_exp.push_back(exp & mask);
    t_mask.push_back(mask);
    t_illegal.push_back(illegal);
  endtask

  task automatic build_table();
    xlen_t word;
    xlen_t mask;
    xlen_t pc;
    xlen_t base;
    xlen_t hpm;
    seed = lcg_next(seed);
    word = seed;
    seed = lcg_next(seed);
    mask = seed;
    seed = lcg_next(seed);
    pc   = seed;
    seed = lcg_next(seed);
    base = seed;
    seed = lcg_next(seed);
    hpm  = seed;
    add_row("mstatus_reset", KOp, CSR_MSTATUS, CSR_OP_READ, 0, 0, 32'h80, '1, 0);
    add_row("mtvec_reset", KOp, CSR_MTVEC, CSR_OP_READ, 0, 0, 32'h1, '1, 0);
    // read, write, set and clear
    add_row("mscratch_write", KOp, CSR_MSCRATCH, CSR_OP_WRITE, word, 0, 0, 0, 0);
    add_row("mscratch_read", KOp, CSR_MSCRATCH, CSR_OP_READ, 0, 0, word, '1, 0);
    add_row("mscratch_set", KOp, CSR_MSCRATCH, CSR_OP_SET, mask, 0, 0, 0, 0);
    add_row("mscratch_or", KOp, CSR_MSCRATCH, CSR_OP_READ, 0, 0, word | mask, '1, 0);
    add_row("mscratch_clear", KOp, CSR_MSCRATCH, CSR_OP_CLEAR, mask, 0, 0, 0, 0);
    add_row("mscratch_andn", KOp, CSR_MSCRATCH, CSR_OP_READ, 0, 0, word & ~mask, '1, 0);
    add_row("mepc_write", KOp, CSR_MEPC, CSR_OP_WRITE, word | 32'h1, 0, 0, 0, 0);
    add_row("mepc_bit0", KOp, CSR_MEPC, CSR_OP_READ, 0, 0, {word[31:1], 1'b0}, '1, 0);
    add_row("mtvec_write", KOp, CSR_MTVEC, CSR_OP_WRITE, word, 0, 0, 0, 0);
    add_row("mtvec_mode", KOp, CSR_MTVEC, CSR_OP_READ, 0, 0, {word[31:8], 8'h01}, '1, 0);
    // illegal accesses and the constant misa
    add_row("unimpl_read", KOp, 12'h7C0, CSR_OP_READ, 0, 0, 0, 0, 1);
    add_row("ro_write", KOp, 12'hC00, CSR_OP_WRITE, word, 0, 0, 0, 1);
    add_row("misa_write", KOp, CSR_MISA, CSR_OP_WRITE, 32'h0, 0, 0, 0, 0);
    add_row("misa_read", KOp, CSR_MISA, CSR_OP_READ, 0, 0, 32'h4010_0104, '1, 0);
    // trap entry from machine mode with mie and tw set
    add_row("mie_on", KOp, CSR_MSTATUS, CSR_OP_WRITE, 32'h0020_0008, 0, 0, 0, 0);
    add_row("mie_read", KOp, CSR_MSTATUS, CSR_OP_READ, 0, 0, 32'h0020_0008, '1, 0);
    add_row("trap_m", KTrap, 0, CSR_OP_READ, pc, 6'h27, 32'h3, '1, 0);
    add_row("trap_mepc", KOp, CSR_MEPC, CSR_OP_READ, 0, 0, pc, '1, 0);
    add_row("trap_mcause", KOp, CSR_MCAUSE, CSR_OP_READ, 0, 0, 32'h8000_0007, '1, 0);
    add_row("trap_mtval", KOp, CSR_MTVAL, CSR_OP_READ, 0, 0, ~pc, '1, 0);
    add_row("trap_mstatus", KOp, CSR_MSTATUS, CSR_OP_READ, 0, 0, 32'h0020_1880, 32'h0020_1888, 0);
    // drop to user mode and come back through a trap
    add_row("mpp_user", KOp, CSR_MSTATUS, CSR_OP_WRITE, 32'h0, 0, 0, 0, 0);
    add_row("mret_user", KMret, 0, CSR_OP_READ, 0, 0, 32'h0, '1, 0);
    add_row("user_mscratch", KOp, CSR_MSCRATCH, CSR_OP_READ, 0, 0, 0, 0, 1);
    add_row("trap_user", KTrap, 0, CSR_OP_READ, word, 6'h02, 32'h3, '1, 0);
    add_row("mstatus_mpp_u", KOp, CSR_MSTATUS, CSR_OP_READ, 0, 0, 32'h0, 32'h0020_1888, 0);
    // interrupts with only the timer enabled
    add_row("mie_timer", KOp, CSR_MIE, CSR_OP_WRITE, 32'h80, 0, 0, 0, 0);
    add_row("irq_timer", KIdle, 0, CSR_OP_READ, 32'h2, 2, 32'h1, 32'h1, 0);
    add_row("mip_timer", KOp, CSR_MIP, CSR_OP_READ, 0, 0, 32'h80, '1, 0);
    add_row("irq_software", KIdle, 0, CSR_OP_READ, 32'h1, 2, 32'h0, 32'h1, 0);
    add_row("mip_software", KOp, CSR_MIP, CSR_OP_READ, 0, 0, 32'h0, '1, 0);
    add_row("irq_quiet", KIdle, 0, CSR_OP_READ, 32'h0, 1, 32'h0, 32'h1, 0);
    // counters
    add_row("inhibit_all", KOp, CSR_MCOUNTINHIBIT, CSR_OP_WRITE, '1, 0, 0, 0, 0);
    add_row("inhibit_read", KOp, CSR_MCOUNTINHIBIT, CSR_OP_READ, 0, 0, 32'hffff_fffd, '1, 0);
    add_row("mcycle_write", KOp, CSR_MCYCLE, CSR_OP_WRITE, base, 0, 0, 0, 0);
    add_row("idle_inhibited", KIdle, 0, CSR_OP_READ, 32'h0, 6, 0, 0, 0);
    add_row("mcycle_held", KOp, CSR_MCYCLE, CSR_OP_READ, 0, 0, base, '1, 0);
    add_row("inhibit_clear", KOp, CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h0, 0, 0, 0, 0);
    add_row("idle_counting", KIdle, 0, CSR_OP_READ, 32'h0, 6, 0, 0, 0);
    add_row("inhibit_set", KOp, CSR_MCOUNTINHIBIT, CSR_OP_WRITE, '1, 0, 0, 0, 0);
    add_row("mcycle_counted", KOp, CSR_MCYCLE, CSR_OP_READ, 0, 0, base + 32'd7, '1, 0);
    add_row("inhibit_off", KOp, CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h0, 0, 0, 0, 0);
    add_row("hpm3_write", KOp, CSR_MHPMCOUNTER3, CSR_OP_WRITE, hpm, 0, 0, 0, 0);
    add_row("load_pulses", KIdle, 0, CSR_OP_READ, 32'h10, 5, 0, 0, 0);
    add_row("hpm3_loads", KOp, CSR_MHPMCOUNTER3, CSR_OP_READ, 0, 0, hpm + 32'd5, '1, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // row execution
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input xlen_t exp, input xlen_t got,
                             inout bit ok);
    assert (got === exp) else begin
      $display("Fail %s: expected %h, actual %h", name, exp, got);
      ok = 1'b0;
    end
  endtask

  // direct outputs that mirror a csr, zero mask when the csr has none
  task automatic sample_port(input csr_addr_t addr, output xlen_t value,
                             output xlen_t mask);
    value = '0;
    mask  = '0;
    case (addr)
      CSR_MTVEC: begin
        value = csr_mtvec_o;
        mask  = '1;
      end
      CSR_MEPC: begin
        value = csr_mepc_o;
        mask  = '1;
      end
      CSR_MSTATUS: begin
        value[MSTATUS_MIE_BIT] = csr_mstatus_mie_o;
        value[MSTATUS_TW_BIT]  = csr_mstatus_tw_o;
        mask[MSTATUS_MIE_BIT]  = 1'b1;
        mask[MSTATUS_TW_BIT]   = 1'b1;
      end
      default: ;
    endcase
  endtask

  task automatic run_row(input int i, output bit ok);
    xlen_t rdata;
    xlen_t port;
    xlen_t port_mask;
    logic  illegal;
    ok = 1'b1;
    case (t_kind[i])
      KOp: begin
        csr_access_i   = 1'b1;
        instr_new_id_i = 1'b1;
        csr_addr_i     = t_addr[i];
        csr_op_i       = t_op[i];
        csr_wdata_i    = t_wdata[i];
        @(negedge clk_i);  // sample mid-cycle
        rdata   = csr_rdata_o;
        illegal = illegal_csr_insn_o;
        sample_port(t_addr[i], port, port_mask);
        @(posedge clk_i);
        #2;
        csr_access_i   = 1'b0;
        instr_new_id_i = 1'b0;
        csr_op_i       = CSR_OP_READ;
        assert (illegal === t_illegal[i]) else begin
          $display("Fail %s: expected illegal %b, actual %b", t_name[i], t_illegal[i], illegal);
          ok = 1'b0;
        end
        if (t_mask[i] != '0) check_value(t_name[i], t_exp[i], rdata & t_mask[i], ok);
        port_mask = port_mask & t_mask[i];
        if (port_mask != '0) begin
          check_value({t_name[i], "_port"}, t_exp[i] & port_mask, port & port_mask, ok);
        end
      end
      KTrap: begin
        csr_save_cause_i = 1'b1;
        csr_save_id_i    = 1'b1;
        pc_id_i          = t_wdata[i];
        csr_mtval_i      = ~t_wdata[i];
        csr_mcause_i     = cause_t'(t_count[i]);
        @(posedge clk_i);
        #2;
        csr_save_cause_i = 1'b0;
        csr_save_id_i    = 1'b0;
        check_value(t_name[i], t_exp[i], xlen_t'(priv_mode_o), ok);
      end
      KMret: begin
        csr_restore_mret_i = 1'b1;
        @(posedge clk_i);
        #2;
        csr_restore_mret_i = 1'b0;
        check_value(t_name[i], t_exp[i], xlen_t'(priv_mode_o), ok);
      end
      default: begin
        irq_software_i = t_wdata[i][0];
        irq_timer_i    = t_wdata[i][1];
        irq_external_i = t_wdata[i][2];
        repeat (t_count[i]) begin
          mem_load_i = t_wdata[i][4];
          @(posedge clk_i);
          #2;
          mem_load_i = 1'b0;
          if (t_wdata[i][4]) begin  // one low cycle between pulses
            @(posedge clk_i);
            #2;
          end
        end
        if (t_mask[i] != '0) check_value(t_name[i], t_exp[i], xlen_t'(irq_pending_o), ok);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // clock, watchdog and main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    wait (table_done);
    repeat (t_name.size() * 40) @(posedge clk_i);
    $display("Error: watchdog expired before all table rows finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    bit ok;
    rst_ni             = 1'b0;
    csr_access_i       = 1'b0;
    csr_addr_i         = '0;
    csr_op_i           = CSR_OP_READ;
    csr_wdata_i        = '0;
    instr_new_id_i     = 1'b0;
    irq_software_i     = 1'b0;
    irq_timer_i        = 1'b0;
    irq_external_i     = 1'b0;
    irq_fast_i         = '0;
    csr_save_cause_i   = 1'b0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_restore_mret_i = 1'b0;
    pc_if_i            = '0;
    pc_id_i            = '0;
    csr_mtval_i        = '0;
    csr_mcause_i       = '0;
    instr_ret_i        = 1'b0;
    mem_load_i         = 1'b0;
    mem_store_i        = 1'b0;
    branch_i           = 1'b0;
    branch_taken_i     = 1'b0;
    errors             = 0;
    passed             = 0;
    seed               = 32'haba8;
    build_table();
    table_done = 1'b1;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i < t_name.size(); i++) begin
      run_row(i, ok);
      if (ok) begin
        passed++;
        $display("test %-16s ok", t_name[i]);
      end else begin
        errors++;
        $display("test %-16s FAILED", t_name[i]);
      end
    end
    prop_fails = csr_unit_inst.u_props.fail_count;
    $display("%0d tests: %0d passed, %0d failed, %0d property failures",
             t_name.size(), passed, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
